/* build.f */
+incdir+include
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/bus_cycle_gen.sv
hdl/mem_decoder.sv
hdl/cpu_ram.sv
hdl/video_ram.sv
hdl/io_port.sv
hdl/keyboard_matrix.sv
hdl/laser310_core.sv
sim/tb_laser310.sv

/* hdl/bus_cycle_gen.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module bus_cycle_gen
	import periph_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic bus_strobe_o
);

	cycle_phase_t phase;
	cycle_phase_t last_phase;
	logic turbo_q;	// Speed of the running cycle
	logic strobe_q;

	assign last_phase = turbo_q ? cycle_phase_t'(`CYCLE_TURBO - 1)
		: cycle_phase_t'(`CYCLE_NORMAL - 1);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase <= '0;
			turbo_q <= 1'b0;
			strobe_q <= 1'b0;
		end
		else
		begin
			strobe_q <= (phase == '0);	// One clock wide, after phase 0
			if (phase == last_phase)
			begin
				phase <= '0;
				turbo_q <= turbo_i;	// Speed only changes at the wrap
			end
			else
				phase <= phase + 1'b1;
		end
	end

	// CPU clock high in the strobe clock only
	assign cpu_clk_o = strobe_q;
	assign bus_strobe_o = strobe_q;

endmodule

/* hdl/bus_pkg.sv */
`include "laser_consts.svh"

package bus_pkg;

	typedef logic [`ADDR_W-1:0] cpu_addr_t;
	typedef logic [`DATA_W-1:0] cpu_data_t;

	// CPU side of the bus, strobes active high
	typedef struct packed
	{
		cpu_addr_t addr;
		cpu_data_t dout;	// Write data from the CPU
		logic mreq;
		logic iorq;
		logic rd;
		logic wr;
	} cpu_bus_t;

endpackage

/* hdl/cpu_ram.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module cpu_ram
	import bus_pkg::*;
#(
	parameter int ADDR_BITS = `RAM_ADDR_W
)
(
	input  logic CLK50MHZ,
	input  cpu_addr_t addr_i,
	input  logic we_i,
	input  cpu_data_t wdata_i,
	output cpu_data_t rdata_o
);

	cpu_data_t mem [0:(1 << ADDR_BITS) - 1];

	// Write-first, new data shows on the read port
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
		begin
			mem[addr_i[ADDR_BITS-1:0]] <= wdata_i;
			rdata_o <= wdata_i;
		end
		else
			rdata_o <= mem[addr_i[ADDR_BITS-1:0]];
	end

endmodule

/* hdl/io_port.sv */
`timescale 1ns/1ps

module io_port
	import bus_pkg::*;
	import periph_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic bus_strobe_i,
	input  logic io_sel_i,
	input  cpu_bus_t bus_i,
	input  logic [5:0] key_col_i,
	input  logic cass_in_i,
	output cpu_data_t key_q_o,
	output io_latch_t io_o
);

	logic latch_wr;

	// Memory write to 6800-6FFF, not a read or port cycle
	assign latch_wr = bus_strobe_i && io_sel_i && bus_i.mreq && bus_i.wr &&
		!bus_i.rd && !bus_i.iorq;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			io_o <= '0;
		else if (latch_wr)
		begin
			io_o.speaker <= {bus_i.dout[0], bus_i.dout[5]};	// Two speaker legs
			io_o.cass_out <= bus_i.dout[2];
			io_o.ag <= bus_i.dout[3];
			io_o.css <= bus_i.dout[4];
		end
	end

	// Bit 7 unused and high, cassette input inverted
	always_ff @(posedge CLK50MHZ)
		if (bus_strobe_i)
			key_q_o <= {1'b1, ~cass_in_i, key_col_i};

endmodule

/* hdl/keyboard_matrix.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module keyboard_matrix
	import periph_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  scan_code_t key_code_i,
	input  logic [7:0] row_sel_i,
	output logic [5:0] key_col_o
);

	key_matrix_t key_q;
	key_ex_t key_ex;
	key_matrix_t key_eff;
	logic key_up;	// Level stored for the strobed key

	assign key_up = ~key_pressed_i;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q <= '1;
			key_ex <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				`SC_T: key_q[`KP_T] <= key_up;
				`SC_W: key_q[`KP_W] <= key_up;
				`SC_E: key_q[`KP_E] <= key_up;
				`SC_Q: key_q[`KP_Q] <= key_up;
				`SC_R: key_q[`KP_R] <= key_up;
				`SC_G: key_q[`KP_G] <= key_up;
				`SC_S: key_q[`KP_S] <= key_up;
				`SC_CTRL: key_q[`KP_CTRL] <= key_up;
				`SC_D: key_q[`KP_D] <= key_up;
				`SC_A: key_q[`KP_A] <= key_up;
				`SC_F: key_q[`KP_F] <= key_up;
				`SC_LSHIFT: key_q[`KP_LSHIFT] <= key_up;
				`SC_SPACE: key_q[`KP_SPACE] <= key_up;
				`SC_RETURN: key_q[`KP_RETURN] <= key_up;
				`SC_RSHIFT: key_ex[0] <= key_up;
				`SC_ESC: key_ex[1] <= key_up;
				`SC_UP: key_ex[2] <= key_up;
				`SC_LEFT: key_ex[3] <= key_up;
				`SC_RIGHT: key_ex[4] <= key_up;
				`SC_DOWN: key_ex[5] <= key_up;
				default: ;	// Keys outside the table are ignored
			endcase
		end
	end

	// Extended keys fold into the matrix as ctrl combinations
	always_comb
	begin
		key_eff = key_q;
		key_eff[`KP_LSHIFT] = key_q[`KP_LSHIFT] & key_ex[0];
		key_eff[`KP_ESC] = key_ex[1];
		key_eff[`KP_UP] = key_ex[2];
		key_eff[`KP_LEFT] = key_ex[3];
		key_eff[`KP_RIGHT] = key_ex[4];
		key_eff[`KP_DOWN] = key_q[`KP_DOWN] & key_ex[5];
		key_eff[`KP_CTRL] = key_q[`KP_CTRL] & (&key_ex[5:1]);
	end

	// A low row select bit enables that row onto the columns
	always_comb
	begin
		logic [7:0] col_rows;
		for (int c = 0; c < 6; c++)
		begin
			for (int r = 0; r < 8; r++)
				col_rows[r] = key_eff[8*r + c];
			key_col_o[c] = &(row_sel_i | col_rows);
		end
	end

endmodule

/* hdl/laser310_core.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module laser310_core
	import bus_pkg::*;
	import periph_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  cpu_bus_t bus_i,
	input  logic turbo_i,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  scan_code_t key_code_i,
	input  logic cass_in_i,
	input  logic [`VRAM_ADDR_W-1:0] vid_addr_i,
	output cpu_data_t rdata_o,
	output logic cpu_clk_o,
	output io_latch_t io_o,
	output cpu_data_t vid_data_o
);

	logic bus_strobe;
	logic ram_we;
	logic vram_we;
	logic io_sel;
	cpu_data_t ram_q;
	cpu_data_t vram_q;
	cpu_data_t key_q;
	logic [5:0] key_col;

	bus_cycle_gen u_cycle (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.turbo_i(turbo_i),
		.cpu_clk_o(cpu_clk_o),
		.bus_strobe_o(bus_strobe)
	);

	mem_decoder u_decoder (
		.bus_i(bus_i),
		.bus_strobe_i(bus_strobe),
		.ram_q_i(ram_q),
		.vram_q_i(vram_q),
		.key_q_i(key_q),
		.ram_we_o(ram_we),
		.vram_we_o(vram_we),
		.io_sel_o(io_sel),
		.rdata_o(rdata_o)
	);

	// 7800 lands at offset 3800, 8000 at offset 0
	cpu_ram #(
		.ADDR_BITS(`RAM_ADDR_W)
	) u_main_ram (
		.CLK50MHZ(CLK50MHZ),
		.addr_i(bus_i.addr),
		.we_i(ram_we),
		.wdata_i(bus_i.dout),
		.rdata_o(ram_q)
	);

	video_ram u_vram (
		.CLK50MHZ(CLK50MHZ),
		.addr_i(bus_i.addr),
		.we_i(vram_we),
		.wdata_i(bus_i.dout),
		.rdata_o(vram_q),
		.vid_addr_i(vid_addr_i),
		.vid_data_o(vid_data_o)
	);

	io_port u_io (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.bus_strobe_i(bus_strobe),
		.io_sel_i(io_sel),
		.bus_i(bus_i),
		.key_col_i(key_col),
		.cass_in_i(cass_in_i),
		.key_q_o(key_q),
		.io_o(io_o)
	);

	keyboard_matrix u_keys (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i),
		.key_code_i(key_code_i),
		.row_sel_i(bus_i.addr[7:0]),	// Row select on A0-A7
		.key_col_o(key_col)
	);

endmodule

/* hdl/mem_decoder.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module mem_decoder
	import bus_pkg::*;
(
	input  cpu_bus_t bus_i,
	input  logic bus_strobe_i,
	input  cpu_data_t ram_q_i,
	input  cpu_data_t vram_q_i,
	input  cpu_data_t key_q_i,
	output logic ram_we_o,
	output logic vram_we_o,
	output logic io_sel_o,
	output cpu_data_t rdata_o
);

	logic [4:0] page;
	logic in_io;
	logic in_vram;
	logic in_ram;
	logic mem_write;

	assign page = bus_i.addr[`ADDR_W-1 -: 5];

	assign in_io = (page == `IO_PAGE);
	assign in_vram = (page == `VRAM_PAGE);

	// 7800-7FFF plus 8000-B7FF, one 16 KB chip
	assign in_ram = (page == `RAM_LOW) ||
		((page >= `RAM_HIGH_FIRST) && (page <= `RAM_HIGH_LAST));

	assign mem_write = bus_strobe_i && bus_i.mreq && bus_i.wr && !bus_i.iorq;

	assign ram_we_o = mem_write && in_ram;
	assign vram_we_o = mem_write && in_vram;
	assign io_sel_o = in_io;

	// ROM space and holes read back as FF
	always_comb
	begin
		if (in_ram)
			rdata_o = ram_q_i;
		else if (in_vram)
			rdata_o = vram_q_i;
		else if (in_io)
			rdata_o = key_q_i;	// Latched at the last strobe
		else
			rdata_o = `UNMAPPED_DATA;
	end

endmodule

/* hdl/periph_pkg.sv */
package periph_pkg;

	typedef logic [7:0] scan_code_t;

	// 0 means pressed, index 8 x row + column
	typedef logic [63:0] key_matrix_t;

	// Extended keys, 0 means pressed
	// bit 0 R-shift, 1 esc, 2 up, 3 left, 4 right, 5 down
	typedef logic [5:0] key_ex_t;

	typedef struct packed
	{
		logic [1:0] speaker;
		logic cass_out;
		logic ag;	// Graphics mode for the video generator
		logic css;	// Colour set
	} io_latch_t;

	typedef logic [3:0] cycle_phase_t;

endpackage

/* hdl/video_ram.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module video_ram
	import bus_pkg::*;
(
	input  logic CLK50MHZ,
	input  cpu_addr_t addr_i,
	input  logic we_i,
	input  cpu_data_t wdata_i,
	output cpu_data_t rdata_o,
	input  logic [`VRAM_ADDR_W-1:0] vid_addr_i,
	output cpu_data_t vid_data_o
);

	cpu_data_t mem [0:(1 << `VRAM_ADDR_W) - 1];

	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
		begin
			mem[addr_i[`VRAM_ADDR_W-1:0]] <= wdata_i;
			rdata_o <= wdata_i;
		end
		else
			rdata_o <= mem[addr_i[`VRAM_ADDR_W-1:0]];
	end

	// Display port never writes
	always_ff @(posedge CLK50MHZ)
		vid_data_o <= mem[vid_addr_i];

endmodule

/* include/laser_consts.svh */
`ifndef LASER_CONSTS_SVH
`define LASER_CONSTS_SVH

// Bus and memory sizes
`define ADDR_W 16
`define DATA_W 8
`define RAM_ADDR_W 14
`define VRAM_ADDR_W 11

// System clocks per CPU cycle
`define CYCLE_NORMAL 14
`define CYCLE_TURBO 4

// Upper five address bits of each region
`define IO_PAGE 5'b01101
`define VRAM_PAGE 5'b01110
`define RAM_LOW 5'b01111
`define RAM_HIGH_FIRST 5'b10000
`define RAM_HIGH_LAST 5'b10110

`define UNMAPPED_DATA 8'hFF

// PS/2 set 2 scan codes
`define SC_Q 8'h15
`define SC_W 8'h1D
`define SC_E 8'h24
`define SC_R 8'h2D
`define SC_T 8'h2C
`define SC_A 8'h1C
`define SC_S 8'h1B
`define SC_D 8'h23
`define SC_F 8'h2B
`define SC_G 8'h34
`define SC_CTRL 8'h14
`define SC_LSHIFT 8'h12
`define SC_RSHIFT 8'h59
`define SC_SPACE 8'h29
`define SC_RETURN 8'h5A
`define SC_ESC 8'h76
`define SC_UP 8'h75
`define SC_LEFT 8'h6B
`define SC_RIGHT 8'h74
`define SC_DOWN 8'h72

// Matrix positions, 8 x row + column
`define KP_T 0
`define KP_W 1
`define KP_E 3
`define KP_Q 4
`define KP_R 5
`define KP_G 8
`define KP_S 9
`define KP_CTRL 10
`define KP_D 11
`define KP_A 12
`define KP_F 13
`define KP_LSHIFT 18
`define KP_UP 33
`define KP_RIGHT 35
`define KP_SPACE 36
`define KP_DOWN 36
`define KP_LEFT 37
`define KP_ESC 42
`define KP_RETURN 50

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_laser310 \
	-o tb_laser310 > build.log 2>&1 &&
./obj_dir/tb_laser310 > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

/* sim/tb_laser310.sv */
`timescale 1ns/1ps
`include "laser_consts.svh"

module tb_laser310
	import bus_pkg::*;
	import periph_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 60000;	// About 300 bus cycles of 14 clocks with wide margin

	logic CLK50MHZ = 1'b0;
	logic RESET_N;
	cpu_bus_t bus;
	logic turbo;
	logic key_strobe;
	logic key_pressed;
	scan_code_t key_code;
	logic cass_in;
	logic [`VRAM_ADDR_W-1:0] vid_addr;
	cpu_data_t rdata;
	cpu_data_t vid_data;
	logic cpu_clk;
	io_latch_t io;

	int err_data = 0;
	int err_io = 0;
	int err_count = 0;
	int cycle_count = 0;
	logic [31:0] rng;
	cpu_data_t ram_model [0:16383];	// Indexed by address minus 7800
	cpu_data_t vram_model [0:2047];
	logic [63:0] keys_down;	// 1 = pressed
	logic [5:0] ext_down;	// R-shift, esc, up, left, right, down

	laser310_core DUT (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.bus_i(bus),
		.turbo_i(turbo),
		.key_strobe_i(key_strobe),
		.key_pressed_i(key_pressed),
		.key_code_i(key_code),
		.cass_in_i(cass_in),
		.vid_addr_i(vid_addr),
		.rdata_o(rdata),
		.cpu_clk_o(cpu_clk),
		.io_o(io),
		.vid_data_o(vid_data)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;

	always @(posedge CLK50MHZ)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout, tests still running after %0d clocks", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu_bus_t make_bus(input cpu_addr_t a, input cpu_data_t d,
		input logic mreq, input logic iorq, input logic rd, input logic wr);
		cpu_bus_t b;
		b.addr = a;
		b.dout = d;
		b.mreq = mreq;
		b.iorq = iorq;
		b.rd = rd;
		b.wr = wr;
		return b;
	endfunction

	function automatic io_latch_t latch_value(input cpu_data_t d);
		io_latch_t v;
		v.speaker = {d[0], d[5]};
		v.cass_out = d[2];
		v.ag = d[3];
		v.css = d[4];
		return v;
	endfunction

	// Matrix position or 64 and up for an extended key
	function automatic int matrix_pos(input scan_code_t code);
		case (code)
			`SC_T: return 0;
			`SC_W: return 1;
			`SC_E: return 3;
			`SC_Q: return 4;
			`SC_R: return 5;
			`SC_G: return 8;
			`SC_S: return 9;
			`SC_CTRL: return 10;
			`SC_D: return 11;
			`SC_A: return 12;
			`SC_F: return 13;
			`SC_LSHIFT: return 18;
			`SC_SPACE: return 36;
			`SC_RETURN: return 50;
			`SC_RSHIFT: return 64;
			`SC_ESC: return 65;
			`SC_UP: return 66;
			`SC_LEFT: return 67;
			`SC_RIGHT: return 68;
			default: return 69;	// Down
		endcase
	endfunction

	function automatic cpu_data_t key_read_value(input logic [7:0] row_sel);
		logic [63:0] eff;
		logic [5:0] cols;
		eff = keys_down;
		eff[18] = eff[18] | ext_down[0];
		eff[42] = eff[42] | ext_down[1];
		eff[33] = eff[33] | ext_down[2];
		eff[37] = eff[37] | ext_down[3];
		eff[35] = eff[35] | ext_down[4];
		eff[36] = eff[36] | ext_down[5];
		eff[10] = eff[10] | (|ext_down[5:1]);	// Esc and arrows are ctrl combinations
		cols = 6'b111111;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 6; c++)
				if (!row_sel[r] && eff[8*r + c])
					cols[c] = 1'b0;
		return {1'b1, ~cass_in, cols};
	endfunction

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			err_data++;
		end
	endtask

	task automatic check_io(input string name, input io_latch_t got, input io_latch_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			err_io++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	// Ends on the falling edge in a cpu_clk_o high clock where a bus cycle starts
	task automatic align_cycle();
		@(negedge CLK50MHZ);
		while (!cpu_clk)
			@(negedge CLK50MHZ);
	endtask

	// Holds the bus until the next CPU clock rise and returns rdata_o from just before it
	task automatic bus_cycle(input cpu_bus_t b, output cpu_data_t q);
		bus = b;
		q = '0;
		@(negedge CLK50MHZ);
		while (!cpu_clk)
		begin
			q = rdata;
			@(negedge CLK50MHZ);
		end
		bus = '0;
	endtask

	task automatic mem_write(input cpu_addr_t a, input cpu_data_t d);
		cpu_data_t q;
		bus_cycle(make_bus(a, d, 1'b1, 1'b0, 1'b0, 1'b1), q);
	endtask

	task automatic mem_read(input cpu_addr_t a, output cpu_data_t q);
		bus_cycle(make_bus(a, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0), q);
	endtask

	task automatic measure_period(output int n);
		n = 1;
		@(negedge CLK50MHZ);
		while (!cpu_clk)
		begin
			@(negedge CLK50MHZ);
			n++;
		end
	endtask

	task automatic key_event(input scan_code_t code, input logic down);
		int pos;
		pos = matrix_pos(code);
		if (pos < 64)
			keys_down[pos] = down;
		else
			ext_down[pos - 64] = down;
		key_code = code;
		key_pressed = down;
		key_strobe = 1'b1;
		@(negedge CLK50MHZ);
		key_strobe = 1'b0;
		while (!cpu_clk)
			@(negedge CLK50MHZ);
	endtask

	task automatic check_key_rows();
		cpu_addr_t rows [6] = '{16'h68FE, 16'h68FD, 16'h68FB, 16'h68EF, 16'h68BF, 16'h6800};
		cpu_data_t q;
		foreach (rows[i])
		begin
			mem_read(rows[i], q);
			check_data($sformatf("rdata_o@%h", rows[i]), q, key_read_value(rows[i][7:0]));
		end
	endtask

	task automatic test_reset_timing();
		int n;
		RESET_N = 1'b0;
		repeat (10) @(negedge CLK50MHZ);
		check_count("cpu_clk_o in reset", int'(cpu_clk !== 1'b0), 0);
		check_io("io_o in reset", io, '0);
		RESET_N = 1'b1;
		align_cycle();
		measure_period(n);
		check_count("normal period", n, 14);
		turbo = 1'b1;
		measure_period(n);
		check_count("period at turbo change", n, 14);	// Speed follows at the wrap
		measure_period(n);
		check_count("turbo period", n, 4);
		turbo = 1'b0;
		measure_period(n);
		check_count("period at turbo release", n, 4);
		measure_period(n);
		check_count("normal period again", n, 14);
	endtask

	task automatic test_main_ram(input logic fast);
		cpu_addr_t addrs [$];
		cpu_data_t q;
		logic [13:0] off;
		turbo = fast;
		addrs = '{16'h7800, 16'h7FFF, 16'h8000, 16'hB7FF};
		repeat (16)
		begin
			rng = lcg_next(rng);
			addrs.push_back(16'h7800 + {2'b00, rng[29:16]});
		end
		foreach (addrs[i])
		begin
			rng = lcg_next(rng);
			off = 14'(addrs[i] - 16'h7800);
			ram_model[off] = rng[31:24];
			mem_write(addrs[i], rng[31:24]);
		end
		foreach (addrs[i])
		begin
			mem_read(addrs[i], q);
			off = 14'(addrs[i] - 16'h7800);
			check_data($sformatf("rdata_o@%h", addrs[i]), q, ram_model[off]);
		end
		turbo = 1'b0;
	endtask

	task automatic test_video_ram();
		cpu_addr_t addrs [$];
		cpu_addr_t holes [7] = '{16'h0000, 16'h1234, 16'h3FFF, 16'h5000, 16'hC000, 16'hE5A5,
			16'hFFFF};
		cpu_data_t q;
		logic [10:0] off;
		addrs = '{16'h7000, 16'h77FF};
		repeat (10)
		begin
			rng = lcg_next(rng);
			addrs.push_back(16'h7000 + {5'b00000, rng[26:16]});
		end
		foreach (addrs[i])
		begin
			rng = lcg_next(rng);
			off = 11'(addrs[i]);
			vram_model[off] = rng[31:24];
			mem_write(addrs[i], rng[31:24]);
		end
		foreach (addrs[i])
		begin
			mem_read(addrs[i], q);
			check_data($sformatf("rdata_o@%h", addrs[i]), q, vram_model[11'(addrs[i])]);
		end
		foreach (addrs[i])
		begin
			vid_addr = 11'(addrs[i]);
			@(negedge CLK50MHZ);
			check_data($sformatf("vid_data_o@%h", vid_addr), vid_data, vram_model[vid_addr]);
		end
		align_cycle();
		foreach (holes[i])
		begin
			mem_read(holes[i], q);
			check_data($sformatf("rdata_o@%h", holes[i]), q, 8'hFF);
		end
		// 0000 shares its low address bits with 8000 and 7000
		mem_write(16'h0000, ~ram_model[14'h0800]);
		mem_read(16'h8000, q);
		check_data("rdata_o@8000", q, ram_model[14'h0800]);
		mem_read(16'h7000, q);
		check_data("rdata_o@7000", q, vram_model[11'h000]);
	endtask

	task automatic test_output_latch();
		cpu_data_t q;
		io_latch_t exp;
		repeat (8)
		begin
			rng = lcg_next(rng);
			exp = latch_value(rng[31:24]);
			mem_write(16'h6800, rng[31:24]);
			check_io("io_o", io, exp);
		end
		exp = latch_value(8'h2D);
		mem_write(16'h6FFF, 8'h2D);	// Top of the I/O page
		check_io("io_o", io, exp);
		mem_read(16'h6800, q);
		check_io("io_o after read", io, exp);
		bus_cycle(make_bus(16'h6800, 8'hD2, 1'b0, 1'b1, 1'b0, 1'b1), q);
		check_io("io_o after port write", io, exp);
	endtask

	task automatic test_keyboard();
		cass_in = 1'b0;
		check_key_rows();
		key_event(`SC_Q, 1'b1);
		key_event(`SC_A, 1'b1);
		key_event(`SC_SPACE, 1'b1);
		key_event(`SC_RETURN, 1'b1);
		check_key_rows();
		key_event(`SC_UP, 1'b1);	// Pulls in ctrl
		key_event(`SC_RSHIFT, 1'b1);
		check_key_rows();
		key_event(`SC_UP, 1'b0);
		key_event(`SC_SPACE, 1'b0);
		key_event(`SC_CTRL, 1'b1);
		key_event(`SC_ESC, 1'b1);
		key_event(`SC_DOWN, 1'b1);
		key_event(`SC_CTRL, 1'b0);
		cass_in = 1'b1;
		check_key_rows();
		key_event(`SC_ESC, 1'b0);
		key_event(`SC_DOWN, 1'b0);
		key_event(`SC_T, 1'b1);
		key_event(`SC_W, 1'b1);
		key_event(`SC_E, 1'b1);
		key_event(`SC_R, 1'b1);
		key_event(`SC_G, 1'b1);
		key_event(`SC_S, 1'b1);
		key_event(`SC_D, 1'b1);
		key_event(`SC_F, 1'b1);
		key_event(`SC_LSHIFT, 1'b1);
		key_event(`SC_LEFT, 1'b1);
		key_event(`SC_RIGHT, 1'b1);
		check_key_rows();
		cass_in = 1'b0;
		key_event(`SC_Q, 1'b0);
		key_event(`SC_RSHIFT, 1'b0);
		key_event(`SC_LEFT, 1'b0);
		check_key_rows();
	endtask

	initial
	begin
		RESET_N = 1'b0;
		bus = '0;
		turbo = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		cass_in = 1'b0;
		vid_addr = '0;
		rng = 32'h119bf4b0;
		keys_down = '0;
		ext_down = '0;
		test_reset_timing();
		test_main_ram(1'b0);
		test_main_ram(1'b1);
		test_video_ram();
		test_output_latch();
		test_keyboard();
		$display("Errors: data %0d, io %0d, count %0d", err_data, err_io, err_count);
		if (err_data + err_io + err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
